// ==== verilog/arcade_ctrl_pkg.sv ====
// Shared types, bit positions and lookup tables for the arcade control block.
// Pads and control bytes are active low. The key vector is active high.
// Scan codes assume PS/2 set 2, the default of a standard keyboard.
package arcade_ctrl_pkg;

  // --------------------------------------------------------------------------
  // Widths that carry a meaning
  // --------------------------------------------------------------------------
  typedef logic [11:0] pad_state_t;   // One pad, 1 = released
  typedef logic [15:0] key_state_t;   // Held keys, 1 = held
  typedef logic [7:0]  ctrl_byte_t;   // Game core input, active low
  typedef logic [7:0]  scan_code_t;   // One PS/2 byte
  typedef logic [4:0]  joy_cnt_t;     // Position in the serial frame
  typedef logic [3:0]  pad_bit_t;     // Bit index inside pad_state_t

  typedef struct packed {
    pad_state_t pad1;
    pad_state_t pad2;
  } pad_pair_t;

  typedef struct packed {
    ctrl_byte_t ctrl1;
    ctrl_byte_t ctrl2;
    logic       game_reset;
    logic       reboot;
  } ctrl_out_t;

  // Pad bit positions, bits 5 and 6 are spare buttons
  localparam pad_bit_t PAD_UP     = 4'd0;
  localparam pad_bit_t PAD_DOWN   = 4'd1;
  localparam pad_bit_t PAD_LEFT   = 4'd2;
  localparam pad_bit_t PAD_RIGHT  = 4'd3;
  localparam pad_bit_t PAD_FIRE   = 4'd4;
  localparam pad_bit_t PAD_MODE   = 4'd7;
  localparam pad_bit_t PAD_START  = 4'd8;
  localparam pad_bit_t PAD_COIN   = 4'd9;
  localparam pad_bit_t PAD_SELECT = 4'd10;
  localparam pad_bit_t PAD_RESET  = 4'd11;

  // Key indices; p2 keys sit KEY_P2_BASE above the p1 ones
  localparam int KEY_UP         = 0;
  localparam int KEY_DOWN       = 1;
  localparam int KEY_LEFT       = 2;
  localparam int KEY_RIGHT      = 3;
  localparam int KEY_FIRE       = 4;
  localparam int KEY_START      = 5;
  localparam int KEY_COIN       = 6;
  localparam int KEY_PER_PLAYER = 7;
  localparam int KEY_P2_BASE    = 7;
  localparam int KEY_GAME_RESET = 14;
  localparam int KEY_REBOOT     = 15;
  localparam int KEY_COUNT      = 16;

  // Control byte bit positions
  localparam int CTRL_COIN  = 7;
  localparam int CTRL_START = 6;
  localparam int CTRL_UP    = 5;
  localparam int CTRL_DOWN  = 4;
  localparam int CTRL_RIGHT = 3;
  localparam int CTRL_LEFT  = 2;
  localparam int CTRL_FIRE  = 1;
  localparam int CTRL_CAB   = 0;   // Cabinet bit on player 2 only

  // --------------------------------------------------------------------------
  // Serial joystick frame, one slot per count from JOY_FIRST_CNT on
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic     pad2;      // 0 = pad1, 1 = pad2
    pad_bit_t bit_idx;
  } joy_slot_t;

  localparam joy_cnt_t JOY_FIRST_CNT = 5'd2;
  localparam joy_cnt_t JOY_LAST_CNT  = 5'd25;
  localparam int       JOY_SLOTS     = 24;

  localparam joy_slot_t JOY_SLOT [JOY_SLOTS] = '{
    '{1'b0, 4'd8},  '{1'b0, 4'd6},  '{1'b0, 4'd5},  '{1'b0, 4'd4},    // Counts 2..5
    '{1'b0, 4'd3},  '{1'b0, 4'd2},  '{1'b0, 4'd1},  '{1'b0, 4'd0},    // 6..9
    '{1'b1, 4'd8},  '{1'b1, 4'd6},  '{1'b1, 4'd5},  '{1'b1, 4'd4},    // 10..13
    '{1'b1, 4'd3},  '{1'b1, 4'd2},  '{1'b1, 4'd1},  '{1'b1, 4'd0},    // 14..17
    '{1'b1, 4'd10}, '{1'b1, 4'd11}, '{1'b1, 4'd9},  '{1'b1, 4'd7},    // 18..21
    '{1'b0, 4'd10}, '{1'b0, 4'd11}, '{1'b0, 4'd9},  '{1'b0, 4'd7}     // 22..25
  };

  // --------------------------------------------------------------------------
  // Scan codes, indexed like key_state_t
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic       ext;     // Needs the E0 prefix
    scan_code_t code;
  } key_code_t;

  localparam key_code_t KEY_TABLE [KEY_COUNT] = '{
    '{1'b1, 8'h75}, '{1'b1, 8'h72}, '{1'b1, 8'h6B}, '{1'b1, 8'h74},   // P1 arrows
    '{1'b0, 8'h14}, '{1'b0, 8'h16}, '{1'b0, 8'h2E},                   // P1 fire start coin
    '{1'b0, 8'h1D}, '{1'b0, 8'h1B}, '{1'b0, 8'h1C}, '{1'b0, 8'h23},   // P2 W S A D
    '{1'b0, 8'h15}, '{1'b0, 8'h1E}, '{1'b0, 8'h36},                   // P2 fire start coin
    '{1'b0, 8'h04}, '{1'b0, 8'h07}                                    // Reset, reboot
  };

  localparam scan_code_t SCAN_BREAK = 8'hF0;
  localparam scan_code_t SCAN_EXT   = 8'hE0;

endpackage

// ==== verilog/joy_serial_reader.sv ====
// Reader for the two-pad serial joystick chain, shifted on ena_x itself.
// A frame is 26 clocks: load low at count 0, then 24 data bits from count 2.
// Both pads update together at frame end; a half frame is never visible.
`timescale 1ns/100ps

module joy_serial_reader (
  input  logic                       ena_x,
  input  logic                       pll_lckd,
  input  logic                       joy_data,
  output logic                       joy_load,
  output arcade_ctrl_pkg::pad_pair_t pads
);

  arcade_ctrl_pkg::joy_cnt_t  frame_cnt;
  arcade_ctrl_pkg::joy_cnt_t  cnt_next;
  arcade_ctrl_pkg::joy_cnt_t  slot_idx;
  arcade_ctrl_pkg::joy_slot_t slot;
  arcade_ctrl_pkg::pad_pair_t shadow;
  arcade_ctrl_pkg::pad_pair_t shadow_nxt;
  logic                       sample_en;

  // --------------------------------------------------------------------------
  // Frame counter and load strobe
  // --------------------------------------------------------------------------
  assign cnt_next = (frame_cnt == arcade_ctrl_pkg::JOY_LAST_CNT) ? '0 : frame_cnt + 5'd1;

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      frame_cnt <= 5'd1;          // Start past the load slot
      joy_load  <= 1'b1;
    end else begin
      frame_cnt <= cnt_next;
      joy_load  <= (cnt_next != '0);   // Low for count 0 only
    end
  end

  // --------------------------------------------------------------------------
  // Bit sampler
  // --------------------------------------------------------------------------
  assign sample_en = (frame_cnt >= arcade_ctrl_pkg::JOY_FIRST_CNT);
  assign slot_idx  = frame_cnt - arcade_ctrl_pkg::JOY_FIRST_CNT;

  always_comb begin
    shadow_nxt = shadow;
    slot       = '0;
    if (sample_en) begin
      slot = arcade_ctrl_pkg::JOY_SLOT[slot_idx];
      if (slot.pad2) begin
        shadow_nxt.pad2[slot.bit_idx] = joy_data;
      end else begin
        shadow_nxt.pad1[slot.bit_idx] = joy_data;
      end
    end
  end

  // Frame being collected slot by slot
  always_ff @(posedge ena_x) begin
    shadow <= shadow_nxt;
  end

  // Publish at the edge that ends count 25, including its own bit
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      pads <= '1;                 // All released
    end else if (frame_cnt == arcade_ctrl_pkg::JOY_LAST_CNT) begin
      pads <= shadow_nxt;
    end
  end

endmodule

// ==== verilog/ps2_key_scanner.sv ====
// PS/2 keyboard scanner producing a vector of held keys.
// The PS/2 bit period must be many ena_x cycles long; edges come from sampling.
// Frames with a bad start, parity or stop bit are dropped without effect.
// PS2_IDLE_CYCLES must be at least 2.
`timescale 1ns/100ps

module ps2_key_scanner #(
  parameter int PS2_IDLE_CYCLES = 2000
) (
  input  logic                        ena_x,
  input  logic                        pll_lckd,
  input  logic                        ps2_clk,
  input  logic                        ps2_data,
  output arcade_ctrl_pkg::key_state_t keys
);

  localparam int IDLE_W = $clog2(PS2_IDLE_CYCLES + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RECV,
    ST_CHECK
  } rx_state_e;

  logic [1:0]                  clk_sync;
  logic [1:0]                  data_sync;
  logic                        clk_prev;
  logic                        clk_fall;
  rx_state_e                   state;
  logic [10:0]                 frame_sr;    // Start bit ends up in bit 0
  logic [3:0]                  bit_cnt;
  logic [IDLE_W-1:0]           idle_cnt;
  logic                        frame_ok;
  arcade_ctrl_pkg::scan_code_t code;
  logic                        brk_pend;
  logic                        ext_pend;
  arcade_ctrl_pkg::key_state_t key_hit;

  // --------------------------------------------------------------------------
  // Synchronizers and falling edge detect
  // --------------------------------------------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync  <= 2'b11;         // Bus idles high
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign clk_fall = clk_prev & ~clk_sync[1];

  // --------------------------------------------------------------------------
  // Frame receiver
  // --------------------------------------------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      state    <= ST_IDLE;
      bit_cnt  <= '0;
      idle_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          idle_cnt <= '0;
          if (clk_fall) begin
            bit_cnt <= 4'd1;      // Start bit taken
            state   <= ST_RECV;
          end
        end
        ST_RECV: begin
          if (clk_fall) begin
            idle_cnt <= '0;
            bit_cnt  <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd10) begin
              state <= ST_CHECK;  // Stop bit just shifted in
            end
          end else if (idle_cnt == IDLE_W'(PS2_IDLE_CYCLES - 1)) begin
            state   <= ST_IDLE;   // Gap inside a frame, drop it
            bit_cnt <= '0;
          end else begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
        ST_CHECK: begin
          state   <= ST_IDLE;
          bit_cnt <= '0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // LSB first, so shift right with the new bit at the top
  always_ff @(posedge ena_x) begin
    if (clk_fall) begin
      frame_sr <= {data_sync[1], frame_sr[10:1]};
    end
  end

  assign code     = frame_sr[8:1];
  assign frame_ok = (state == ST_CHECK) && !frame_sr[0] && frame_sr[10]
                    && (^frame_sr[9:1]);      // Odd parity over data and parity

  // --------------------------------------------------------------------------
  // Make/break decoder
  // --------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < arcade_ctrl_pkg::KEY_COUNT; i++) begin
      key_hit[i] = (arcade_ctrl_pkg::KEY_TABLE[i].code == code) &&
                   (arcade_ctrl_pkg::KEY_TABLE[i].ext == ext_pend);
    end
  end

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      keys     <= '0;
      brk_pend <= 1'b0;
      ext_pend <= 1'b0;
    end else if (frame_ok) begin
      if (code == arcade_ctrl_pkg::SCAN_BREAK) begin
        brk_pend <= 1'b1;
      end else if (code == arcade_ctrl_pkg::SCAN_EXT) begin
        ext_pend <= 1'b1;
      end else begin
        keys     <= brk_pend ? (keys & ~key_hit) : (keys | key_hit);  // No hit, no change
        brk_pend <= 1'b0;
        ext_pend <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/control_merger.sv ====
// Merges pad and keyboard state into the two active-low game control bytes.
// All outputs are registered one cycle after their inputs.
// game_reset stays high RESET_HOLD cycles after the request drops (>= 1).
`timescale 1ns/100ps

module control_merger #(
  parameter int RESET_HOLD      = 16,
  parameter bit CABINET_UPRIGHT = 1'b1
) (
  input  logic                        ena_x,
  input  logic                        pll_lckd,
  input  arcade_ctrl_pkg::pad_pair_t  pads,
  input  arcade_ctrl_pkg::key_state_t keys,
  output arcade_ctrl_pkg::ctrl_out_t  ctrl
);

  localparam int HOLD_W = $clog2(RESET_HOLD + 1);

  logic [HOLD_W-1:0]           hold_cnt;
  logic                        rst_req;
  logic                        reboot_req;
  arcade_ctrl_pkg::ctrl_byte_t ctrl1_nxt;
  arcade_ctrl_pkg::ctrl_byte_t ctrl2_nxt;

  // Button released only if the pad says so and no key holds it
  function automatic arcade_ctrl_pkg::ctrl_byte_t map_player(
    input arcade_ctrl_pkg::pad_state_t pad,
    input logic [6:0]                  held,
    input logic                        bit0
  );
    arcade_ctrl_pkg::ctrl_byte_t b;
    b[arcade_ctrl_pkg::CTRL_COIN]  = pad[arcade_ctrl_pkg::PAD_COIN]
                                     & ~held[arcade_ctrl_pkg::KEY_COIN];
    b[arcade_ctrl_pkg::CTRL_START] = pad[arcade_ctrl_pkg::PAD_START]
                                     & ~held[arcade_ctrl_pkg::KEY_START];
    b[arcade_ctrl_pkg::CTRL_UP]    = pad[arcade_ctrl_pkg::PAD_UP]
                                     & ~held[arcade_ctrl_pkg::KEY_UP];
    b[arcade_ctrl_pkg::CTRL_DOWN]  = pad[arcade_ctrl_pkg::PAD_DOWN]
                                     & ~held[arcade_ctrl_pkg::KEY_DOWN];
    b[arcade_ctrl_pkg::CTRL_RIGHT] = pad[arcade_ctrl_pkg::PAD_RIGHT]
                                     & ~held[arcade_ctrl_pkg::KEY_RIGHT];
    b[arcade_ctrl_pkg::CTRL_LEFT]  = pad[arcade_ctrl_pkg::PAD_LEFT]
                                     & ~held[arcade_ctrl_pkg::KEY_LEFT];
    b[arcade_ctrl_pkg::CTRL_FIRE]  = pad[arcade_ctrl_pkg::PAD_FIRE]
                                     & ~held[arcade_ctrl_pkg::KEY_FIRE];
    b[arcade_ctrl_pkg::CTRL_CAB]   = bit0;
    return b;
  endfunction

  assign ctrl1_nxt = map_player(pads.pad1, keys[arcade_ctrl_pkg::KEY_PER_PLAYER-1:0], 1'b0);
  assign ctrl2_nxt = map_player(pads.pad2,
                                keys[arcade_ctrl_pkg::KEY_P2_BASE +: arcade_ctrl_pkg::KEY_PER_PLAYER],
                                CABINET_UPRIGHT);

  // Pad reset button is active low like every other pad bit
  assign rst_req    = keys[arcade_ctrl_pkg::KEY_GAME_RESET]
                      | ~pads.pad1[arcade_ctrl_pkg::PAD_RESET];
  assign reboot_req = keys[arcade_ctrl_pkg::KEY_REBOOT]
                      | ~pads.pad2[arcade_ctrl_pkg::PAD_RESET];

  // --------------------------------------------------------------------------
  // Output registers and reset stretch
  // --------------------------------------------------------------------------
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      ctrl.ctrl1      <= 8'hFE;
      ctrl.ctrl2      <= {7'h7F, CABINET_UPRIGHT};
      ctrl.game_reset <= 1'b0;
      ctrl.reboot     <= 1'b0;
      hold_cnt        <= '0;
    end else begin
      ctrl.ctrl1  <= ctrl1_nxt;
      ctrl.ctrl2  <= ctrl2_nxt;
      ctrl.reboot <= reboot_req;
      if (rst_req) begin
        ctrl.game_reset <= 1'b1;
        hold_cnt        <= HOLD_W'(RESET_HOLD - 1);   // Cycles left after the first low one
      end else if (hold_cnt != '0) begin
        ctrl.game_reset <= 1'b1;
        hold_cnt        <= hold_cnt - 1'b1;
      end else begin
        ctrl.game_reset <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/arcade_ctrl_top.sv ====
// Player input block for the arcade port: serial joysticks plus PS/2 keys.
// The joystick chain is shifted by ena_x directly, exported as joy_clk.
// No handshakes; all outputs are plain levels updated on ena_x.
`timescale 1ns/100ps

module arcade_ctrl_top #(
  parameter int PS2_IDLE_CYCLES = 2000,
  parameter int RESET_HOLD      = 16,
  parameter bit CABINET_UPRIGHT = 1'b1
) (
  input  logic                       ena_x,
  input  logic                       pll_lckd,
  input  logic                       joy_data,
  input  logic                       ps2_clk,
  input  logic                       ps2_data,
  output logic                       joy_clk,
  output logic                       joy_load,
  output arcade_ctrl_pkg::ctrl_out_t ctrl
);

  arcade_ctrl_pkg::pad_pair_t  pads;
  arcade_ctrl_pkg::key_state_t keys;

  assign joy_clk = ena_x;   // Chain shifts on the same clock

  joy_serial_reader i_joy (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .joy_data (joy_data),
    .joy_load (joy_load),
    .pads     (pads)
  );

  ps2_key_scanner #(
    .PS2_IDLE_CYCLES (PS2_IDLE_CYCLES)
  ) i_ps2 (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .keys     (keys)
  );

  control_merger #(
    .RESET_HOLD      (RESET_HOLD),
    .CABINET_UPRIGHT (CABINET_UPRIGHT)
  ) i_merge (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .pads     (pads),
    .keys     (keys),
    .ctrl     (ctrl)
  );

endmodule

// ==== test/arcade_ctrl_assertions.sv ====
// Concurrent checks bound into arcade_ctrl_top.
// Covers the joystick load period, the cabinet bit, reset stretch and reboot delay.
// fail_cnt is read by the testbench at the end of the run.
`timescale 1ns/100ps

module arcade_ctrl_assertions #(
  parameter int RESET_HOLD      = 16,
  parameter bit CABINET_UPRIGHT = 1'b1
) (
  input logic                        ena_x,
  input logic                        pll_lckd,
  input logic                        joy_load,
  input arcade_ctrl_pkg::pad_pair_t  pads,
  input arcade_ctrl_pkg::key_state_t keys,
  input arcade_ctrl_pkg::ctrl_out_t  ctrl
);

  int   fail_cnt = 0;
  int   load_gap;               // High cycles since the last load
  logic load_seen;
  int   since_req;              // Cycles since the reset request, saturates
  logic rst_req;
  logic reboot_req;

  assign rst_req    = keys[arcade_ctrl_pkg::KEY_GAME_RESET]
                      | ~pads.pad1[arcade_ctrl_pkg::PAD_RESET];
  assign reboot_req = keys[arcade_ctrl_pkg::KEY_REBOOT]
                      | ~pads.pad2[arcade_ctrl_pkg::PAD_RESET];

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      load_gap  <= 0;
      load_seen <= 1'b0;
      since_req <= RESET_HOLD;  // No request yet
    end else begin
      if (!joy_load) begin
        load_gap  <= 0;
        load_seen <= 1'b1;
      end else begin
        load_gap <= load_gap + 1;
      end
      if (rst_req) begin
        since_req <= 0;
      end else if (since_req < RESET_HOLD) begin
        since_req <= since_req + 1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Load strobe, one low cycle in every 26
  // --------------------------------------------------------------------------
  a_load_period: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (!joy_load && load_seen) |-> load_gap == 25)
    else begin
      fail_cnt++;
      $error("joy_load period is not 26 cycles");
    end

  a_load_missing: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    joy_load |-> load_gap < 25)
    else begin
      fail_cnt++;
      $error("joy_load stayed high past a frame");
    end

  a_load_width: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |=> joy_load)
    else begin
      fail_cnt++;
      $error("joy_load low for more than one cycle");
    end

  // Cabinet bit on player 2, fixed 0 on player 1
  a_cabinet: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    ctrl.ctrl2[arcade_ctrl_pkg::CTRL_CAB] == CABINET_UPRIGHT &&
    ctrl.ctrl1[arcade_ctrl_pkg::CTRL_CAB] == 1'b0)
    else begin
      fail_cnt++;
      $error("cabinet bit changed");
    end

  // High one cycle after the request, low RESET_HOLD cycles after it ends
  a_reset_stretch: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    ctrl.game_reset == (since_req < RESET_HOLD))
    else begin
      fail_cnt++;
      $error("game_reset stretch timing wrong");
    end

  a_reboot: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    ctrl.reboot == $past(reboot_req))
    else begin
      fail_cnt++;
      $error("reboot does not follow its request");
    end

endmodule

// ==== test/arcade_ctrl_tb.sv ====
// Testbench for the arcade control block with a joystick chain and a PS/2 keyboard model.
// Expected ctrl values follow the pad and key mapping rules of the control bytes.
// Load period, cabinet bit and reset stretch are checked by the bound assertions.
// PS/2 bits last 20 clocks, far longer than the two flop synchronizer.
`timescale 1ns/100ps

module arcade_ctrl_tb;

  localparam int CLK_PERIOD      = 100;
  localparam int DRV_DELAY       = 10;            // Input change after the rising edge
  localparam int PS2_IDLE        = 200;
  localparam int HOLD            = 16;
  localparam int WATCHDOG_CYCLES = 2 * (40 * 26 + 30 * 240 + 2 * PS2_IDLE);
  localparam logic [31:0] SEED   = 32'h6b29d30b;

  logic                        ena_x;
  logic                        pll_lckd;
  logic                        joy_data;
  logic                        ps2_clk;
  logic                        ps2_data;
  logic                        joy_clk;
  logic                        joy_load;
  arcade_ctrl_pkg::ctrl_out_t  ctrl;

  arcade_ctrl_pkg::pad_pair_t  next_pads;       // Queued for the next frame
  arcade_ctrl_pkg::pad_pair_t  tx_pads;         // Frame on the chain now
  arcade_ctrl_pkg::pad_pair_t  exp_pads;        // Reference model state
  arcade_ctrl_pkg::key_state_t exp_keys;
  logic [31:0]                 rng;
  int                          joy_pos;         // Clocks since the last load
  int                          cmp_errs;
  logic                        rst_req_q;
  logic                        rst_seen;
  time                         rst_end;         // When the reset request last dropped

  arcade_ctrl_top #(
    .PS2_IDLE_CYCLES (PS2_IDLE),
    .RESET_HOLD      (HOLD),
    .CABINET_UPRIGHT (1'b1)
  ) i_dut (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .joy_data (joy_data),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .joy_clk  (joy_clk),
    .joy_load (joy_load),
    .ctrl     (ctrl)
  );

  bind arcade_ctrl_top arcade_ctrl_assertions #(
    .RESET_HOLD      (RESET_HOLD),
    .CABINET_UPRIGHT (CABINET_UPRIGHT)
  ) i_chk (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .joy_load (joy_load),
    .pads     (pads),
    .keys     (keys),
    .ctrl     (ctrl)
  );

  always #(CLK_PERIOD / 2) ena_x = ~ena_x;

  // --------------------------------------------------------------------------
  // Reference rules
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Pad bit released and key not held gives a 1
  function automatic arcade_ctrl_pkg::ctrl_byte_t player_byte(
    input arcade_ctrl_pkg::pad_state_t pad,
    input logic [6:0]                  held,
    input logic                        bit0
  );
    arcade_ctrl_pkg::ctrl_byte_t b;
    b[7] = pad[9] & ~held[6];   // Coin
    b[6] = pad[8] & ~held[5];   // Start
    b[5] = pad[0] & ~held[0];   // Up
    b[4] = pad[1] & ~held[1];   // Down
    b[3] = pad[3] & ~held[3];   // Right
    b[2] = pad[2] & ~held[2];   // Left
    b[1] = pad[4] & ~held[4];   // Fire
    b[0] = bit0;
    return b;
  endfunction

  function automatic int key_index(input arcade_ctrl_pkg::scan_code_t code, input logic ext);
    for (int i = 0; i < arcade_ctrl_pkg::KEY_COUNT; i++) begin
      if (arcade_ctrl_pkg::KEY_TABLE[i].code == code &&
          arcade_ctrl_pkg::KEY_TABLE[i].ext == ext) begin
        return i;
      end
    end
    return -1;                  // Not a game key
  endfunction

  // Chain bit for one frame position, idle high outside the data slots
  function automatic logic frame_bit(input int pos, input arcade_ctrl_pkg::pad_pair_t p);
    arcade_ctrl_pkg::joy_slot_t s;
    if (pos < 2 || pos > 25) begin
      return 1'b1;
    end
    s = arcade_ctrl_pkg::JOY_SLOT[pos - 2];
    return s.pad2 ? p.pad2[s.bit_idx] : p.pad1[s.bit_idx];
  endfunction

  // --------------------------------------------------------------------------
  // Joystick chain model, restarts its count at each load cycle
  // --------------------------------------------------------------------------
  always @(posedge ena_x) begin
    #DRV_DELAY;
    if (!joy_load) begin
      joy_pos = 0;
      tx_pads = next_pads;      // Parallel load of both pads
    end else if (joy_pos < 26) begin
      joy_pos++;
    end
    joy_data = frame_bit(joy_pos, tx_pads);
  end

  // Chain clock must follow ena_x in both phases
  always @(ena_x) begin
    #DRV_DELAY;
    if (joy_clk !== ena_x) begin
      cmp_errs++;
      $display("[FAIL] %0d ns joy_clk %b while ena_x %b", $time, joy_clk, ena_x);
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------------------------------
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge ena_x);
      #DRV_DELAY;
    end
  endtask

  task automatic wait_load();
    do begin
      @(posedge ena_x);
      #(2 * DRV_DELAY);
    end while (joy_load);
  endtask

  task automatic update_reset_req();
    logic req;
    req = exp_keys[14] | ~exp_pads.pad1[11];
    if (rst_req_q && !req) begin
      rst_end = $time;
    end
    if (req) begin
      rst_seen = 1'b1;
    end
    rst_req_q = req;
  endtask

  task automatic check_ctrl(input string what);
    arcade_ctrl_pkg::ctrl_byte_t exp1;
    arcade_ctrl_pkg::ctrl_byte_t exp2;
    logic                        exp_reboot;
    logic                        settled;
    exp1       = player_byte(exp_pads.pad1, exp_keys[6:0], 1'b0);
    exp2       = player_byte(exp_pads.pad2, exp_keys[13:7], 1'b1);
    exp_reboot = exp_keys[15] | ~exp_pads.pad2[11];
    settled    = !rst_seen || ($time - rst_end > (HOLD + 4) * CLK_PERIOD);  // Stretch over
    if (ctrl.ctrl1 !== exp1 || ctrl.ctrl2 !== exp2 || ctrl.reboot !== exp_reboot) begin
      cmp_errs++;
      $display("[FAIL] %0d ns %s: ctrl1 %h exp %h, ctrl2 %h exp %h, reboot %b exp %b",
               $time, what, ctrl.ctrl1, exp1, ctrl.ctrl2, exp2, ctrl.reboot, exp_reboot);
    end
    if ((rst_req_q && ctrl.game_reset !== 1'b1) ||
        (!rst_req_q && settled && ctrl.game_reset !== 1'b0)) begin
      cmp_errs++;
      $display("[FAIL] %0d ns %s: game_reset %b with request %b",
               $time, what, ctrl.game_reset, rst_req_q);
    end
  endtask

  // Frame goes out at the next load, shows up at the one after
  task automatic send_pads(input arcade_ctrl_pkg::pad_pair_t p, input string what);
    @(negedge ena_x);
    next_pads = p;
    wait_load();
    wait_load();
    tick(2);
    exp_pads = p;
    update_reset_req();
    check_ctrl(what);
  endtask

  // PS/2 frame LSB first; nbits below 11 cuts it short
  task automatic ps2_frame(input arcade_ctrl_pkg::scan_code_t code, input int nbits,
                           input logic bad_par);
    logic [10:0] bits;
    bits = {1'b1, ~(^code) ^ bad_par, code, 1'b0};
    for (int i = 0; i < nbits; i++) begin
      ps2_data = bits[i];
      tick(10);
      ps2_clk = 1'b0;           // Device shifts on the falling edge
      tick(10);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    tick(10);
  endtask

  task automatic key_event(input arcade_ctrl_pkg::scan_code_t code, input logic ext,
                           input logic brk, input string what);
    int idx;
    if (ext) begin
      ps2_frame(arcade_ctrl_pkg::SCAN_EXT, 11, 1'b0);
    end
    if (brk) begin
      ps2_frame(arcade_ctrl_pkg::SCAN_BREAK, 11, 1'b0);
    end
    ps2_frame(code, 11, 1'b0);
    idx = key_index(code, ext);
    if (idx >= 0) begin
      exp_keys[idx] = !brk;
    end
    update_reset_req();
    check_ctrl(what);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    ena_x     = 1'b0;
    pll_lckd  = 1'b0;
    joy_data  = 1'b1;
    ps2_clk   = 1'b1;           // PS/2 bus idles high
    ps2_data  = 1'b1;
    next_pads = '1;
    tx_pads   = '1;
    exp_pads  = '1;
    exp_keys  = '0;
    rng       = SEED;
    joy_pos   = 26;
    cmp_errs  = 0;
    rst_req_q = 1'b0;
    rst_seen  = 1'b0;
    rst_end   = 0;
    repeat (4) @(posedge ena_x);
    #DRV_DELAY;
    pll_lckd = 1'b1;
    tick(2);
    check_ctrl("after reset");

    for (int n = 0; n < 12; n++) begin
      rng = xorshift32(rng);
      send_pads(rng[23:0], "random pads");
    end
    send_pads('1, "pads released");

    key_event(8'h14, 1'b0, 1'b0, "p1 fire make");
    key_event(8'h14, 1'b0, 1'b1, "p1 fire break");
    key_event(8'h36, 1'b0, 1'b0, "p2 coin make");
    key_event(8'h36, 1'b0, 1'b1, "p2 coin break");
    key_event(8'h75, 1'b1, 1'b0, "extended up make");
    key_event(8'h75, 1'b1, 1'b1, "extended up break");
    key_event(8'h75, 1'b0, 1'b0, "plain 75 make");
    key_event(8'h75, 1'b0, 1'b1, "plain 75 break");

    // Broken frames leave the keys alone
    ps2_frame(8'h14, 11, 1'b1);
    check_ctrl("bad parity frame");
    ps2_frame(8'h14, 5, 1'b0);
    tick(PS2_IDLE + 20);
    check_ctrl("cut frame");
    key_event(8'h14, 1'b0, 1'b0, "p1 fire after bad frames");
    key_event(8'h14, 1'b0, 1'b1, "p1 fire release");

    // Reset and reboot requests
    key_event(8'h04, 1'b0, 1'b0, "reset key make");
    key_event(8'h04, 1'b0, 1'b1, "reset key break");
    tick(HOLD + 6);
    check_ctrl("reset key stretch over");
    send_pads({12'h7FF, 12'hFFF}, "pad1 reset button");
    send_pads('1, "pad1 reset released");
    tick(HOLD + 6);
    check_ctrl("pad reset stretch over");
    key_event(8'h07, 1'b0, 1'b0, "reboot key make");
    key_event(8'h07, 1'b0, 1'b1, "reboot key break");
    send_pads({12'hFFF, 12'h7FF}, "pad2 reset button");
    send_pads('1, "pad2 reset released");

    tick(4);
    $display("Errors: %0d compare, %0d assertion", cmp_errs, i_dut.i_chk.fail_cnt);
    if (cmp_errs == 0 && i_dut.i_chk.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ena_x);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== arcade_ctrl.f ====
verilog/arcade_ctrl_pkg.sv
verilog/joy_serial_reader.sv
verilog/ps2_key_scanner.sv
verilog/control_merger.sv
verilog/arcade_ctrl_top.sv
test/arcade_ctrl_assertions.sv
test/arcade_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the arcade control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Checks failed"

verilator --binary --timing --assert -Wno-fatal \
  --top-module arcade_ctrl_tb -f arcade_ctrl.f \
  --Mdir obj_dir -o arcade_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/arcade_ctrl_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if grep -q "$FAIL_MSG" "$LOG"; then
  exit 1
fi
exit 0
